//--- design/isa_pkg.sv
package isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;     // data or address word
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;  // gpr number

    // first fetch after reset
    localparam word_t RESET_PC = '0;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;   // r-type, decoded by funct
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // funct codes for OP_SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_SLT  = 6'b101010;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,   // signed compare
        ALU_LUI    // upper half from operand b
    } alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        alu_op_t           alu_op;
        isa_pkg::word_t    src_a;       // rs value after forwarding
        isa_pkg::word_t    src_b;       // rt value after forwarding
        isa_pkg::word_t    imm;         // sign extended
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t dst;
        logic              reg_write;
        logic              load;
        logic              store;
        logic              branch;
        logic              use_imm;
    } id_exe_t;

    // execute to memory
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    result;      // alu result, also the data address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t dst;
        logic              reg_write;
        logic              load;
        logic              store;
    } exe_mem_t;

    // memory to write-back
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    result;
        isa_pkg::reg_idx_t dst;
        logic              reg_write;
    } mem_wb_t;

    // a produced register value, for bypass and rf write
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t dst;
        isa_pkg::word_t    value;
    } fwd_t;

    // data port request, answered in the same cycle
    typedef struct packed {
        logic           enable;
        logic           write;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } dmem_req_t;

endpackage

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             dep_stall,
    input  logic             branch_taken,
    input  isa_pkg::word_t   branch_target,
    output isa_pkg::word_t   inst_addr,
    input  isa_pkg::word_t   inst_rdata,
    output pipe_pkg::if_id_t if_id
);

    isa_pkg::word_t pc;

    assign inst_addr = pc;  // instruction port answers this cycle

    // branch redirect wins over a stall
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= isa_pkg::RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!dep_stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else if (branch_taken) begin
            if_id <= '0;  // wrong-path word dropped
        end else if (!dep_stall) begin
            if_id <= '{valid: 1'b1, pc: pc, instr: inst_rdata};
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              aclk,
    input  logic              arst_n,
    input  isa_pkg::reg_idx_t ra,
    input  isa_pkg::reg_idx_t rb,
    output isa_pkg::word_t    rdata_a,
    output isa_pkg::word_t    rdata_b,
    input  pipe_pkg::fwd_t    wr
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.dst != '0) begin
            regs[wr.dst] <= wr.value;
        end
    end

    // $0 is hardwired, a same-cycle write passes straight through
    assign rdata_a = (ra == '0)                  ? '0       :
                     (wr.we && wr.dst == ra)     ? wr.value : regs[ra];
    assign rdata_b = (rb == '0)                  ? '0       :
                     (wr.we && wr.dst == rb)     ? wr.value : regs[rb];

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  pipe_pkg::if_id_t   if_id,
    input  pipe_pkg::exe_mem_t exe_mem,
    input  pipe_pkg::fwd_t     mem_fwd,
    input  pipe_pkg::fwd_t     wb_fwd,
    input  logic               branch_taken,
    output logic               dep_stall,
    output pipe_pkg::id_exe_t  id_exe
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    imm_sext;
    isa_pkg::word_t    rf_a;
    isa_pkg::word_t    rf_b;
    isa_pkg::word_t    opnd_a;
    isa_pkg::word_t    opnd_b;
    logic              uses_rs;
    logic              uses_rt;
    logic              exe_writes;
    pipe_pkg::id_exe_t id_exe_d;

    // newest value of a source: memory stage, then write-back, then rf
    function automatic isa_pkg::word_t pick_operand(
        input isa_pkg::reg_idx_t  src,
        input isa_pkg::word_t     rf_val,
        input pipe_pkg::exe_mem_t mem_stage,
        input pipe_pkg::fwd_t     mem_val,
        input pipe_pkg::fwd_t     wb_val
    );
        isa_pkg::word_t val;
        val = rf_val;
        if (src == '0) begin
            val = '0;
        end else if (mem_stage.valid && mem_stage.reg_write && mem_stage.dst == src) begin
            val = mem_val.value;  // includes load data
        end else if (wb_val.we && wb_val.dst == src) begin
            val = wb_val.value;
        end
        return val;
    endfunction

    assign opcode   = if_id.instr[31:26];
    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign rd       = if_id.instr[15:11];
    assign funct    = if_id.instr[5:0];
    assign imm_sext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

    reg_file u_reg_file (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .ra      (rs),
        .rb      (rt),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .wr      (wb_fwd)
    );

    assign opnd_a = pick_operand(rs, rf_a, exe_mem, mem_fwd, wb_fwd);
    assign opnd_b = pick_operand(rt, rf_b, exe_mem, mem_fwd, wb_fwd);

    always_comb begin
        id_exe_d            = '0;
        id_exe_d.valid      = if_id.valid;
        id_exe_d.pc         = if_id.pc;
        id_exe_d.alu_op     = pipe_pkg::ALU_ADD;
        id_exe_d.src_a      = opnd_a;
        id_exe_d.src_b      = opnd_b;
        id_exe_d.imm        = imm_sext;
        id_exe_d.store_data = opnd_b;
        id_exe_d.dst        = rd;
        uses_rs             = 1'b0;
        uses_rt             = 1'b0;
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                uses_rs            = 1'b1;
                uses_rt            = 1'b1;
                id_exe_d.reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: id_exe_d.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: id_exe_d.alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  id_exe_d.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   id_exe_d.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  id_exe_d.alu_op = pipe_pkg::ALU_SLT;
                    default:          id_exe_d.reg_write = 1'b0;  // treated as nop
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                uses_rs            = 1'b1;
                id_exe_d.dst       = rt;
                id_exe_d.reg_write = 1'b1;
                id_exe_d.use_imm   = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                id_exe_d.alu_op    = pipe_pkg::ALU_LUI;
                id_exe_d.dst       = rt;
                id_exe_d.reg_write = 1'b1;
                id_exe_d.use_imm   = 1'b1;
            end
            isa_pkg::OP_LW: begin
                uses_rs            = 1'b1;
                id_exe_d.dst       = rt;
                id_exe_d.reg_write = 1'b1;
                id_exe_d.load      = 1'b1;
                id_exe_d.use_imm   = 1'b1;
            end
            isa_pkg::OP_SW: begin
                uses_rs            = 1'b1;
                uses_rt            = 1'b1;  // store data
                id_exe_d.store     = 1'b1;
                id_exe_d.use_imm   = 1'b1;
            end
            isa_pkg::OP_BEQ: begin
                uses_rs            = 1'b1;
                uses_rt            = 1'b1;
                id_exe_d.branch    = 1'b1;
            end
            default: ;
        endcase
    end

    // execute result is not bypassed, so wait one cycle for it
    assign exe_writes = id_exe.valid && id_exe.reg_write && (id_exe.dst != '0);
    assign dep_stall  = if_id.valid && exe_writes &&
                        ((uses_rs && rs == id_exe.dst) || (uses_rt && rt == id_exe.dst));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            id_exe <= '0;
        end else if (branch_taken || dep_stall) begin
            id_exe <= '0;  // bubble
        end else begin
            id_exe <= id_exe_d;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               aclk,
    input  logic               arst_n,
    input  pipe_pkg::id_exe_t  id_exe,
    output logic               branch_taken,
    output isa_pkg::word_t     branch_target,
    output pipe_pkg::exe_mem_t exe_mem
);

    isa_pkg::word_t alu_b;
    isa_pkg::word_t alu_out;
    logic           slt_bit;
    logic           operands_equal;

    assign alu_b   = id_exe.use_imm ? id_exe.imm : id_exe.src_b;
    assign slt_bit = $signed(id_exe.src_a) < $signed(alu_b);

    always_comb begin
        case (id_exe.alu_op)
            pipe_pkg::ALU_ADD: alu_out = id_exe.src_a + alu_b;
            pipe_pkg::ALU_SUB: alu_out = id_exe.src_a - alu_b;
            pipe_pkg::ALU_AND: alu_out = id_exe.src_a & alu_b;
            pipe_pkg::ALU_OR:  alu_out = id_exe.src_a | alu_b;
            pipe_pkg::ALU_SLT: alu_out = {{(isa_pkg::XLEN-1){1'b0}}, slt_bit};
            pipe_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
            default:           alu_out = '0;
        endcase
    end

    // beq only, no delay slot
    assign operands_equal = (id_exe.src_a == id_exe.src_b);
    assign branch_taken   = id_exe.valid && id_exe.branch && operands_equal;
    assign branch_target  = id_exe.pc + 32'd4 + {id_exe.imm[29:0], 2'b00};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem <= '0;
        end else begin
            exe_mem <= '{
                valid:      id_exe.valid,
                pc:         id_exe.pc,
                result:     alu_out,
                store_data: id_exe.store_data,
                dst:        id_exe.dst,
                reg_write:  id_exe.reg_write,
                load:       id_exe.load,
                store:      id_exe.store
            };
        end
    end

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  pipe_pkg::exe_mem_t  exe_mem,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata,
    output pipe_pkg::fwd_t      mem_fwd,
    output pipe_pkg::mem_wb_t   mem_wb
);

    isa_pkg::word_t mem_value;

    assign dmem_req.enable = exe_mem.valid && (exe_mem.load || exe_mem.store);
    assign dmem_req.write  = exe_mem.valid && exe_mem.store;
    assign dmem_req.addr   = exe_mem.result;
    assign dmem_req.wdata  = exe_mem.store_data;

    // read data is back in the same cycle
    assign mem_value = exe_mem.load ? dmem_rdata : exe_mem.result;

    assign mem_fwd.we    = exe_mem.valid && exe_mem.reg_write && (exe_mem.dst != '0);
    assign mem_fwd.dst   = exe_mem.dst;
    assign mem_fwd.value = mem_value;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{
                valid:     exe_mem.valid,
                pc:        exe_mem.pc,
                result:    mem_value,
                dst:       exe_mem.dst,
                reg_write: exe_mem.reg_write
            };
        end
    end

endmodule

//--- design/mips_core_top.sv
`timescale 1ns/1ps

module mips_core_top (
    input  logic                aclk,
    input  logic                arst_n,
    output isa_pkg::word_t      inst_addr,
    input  isa_pkg::word_t      inst_rdata,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata,
    output isa_pkg::word_t      debug_wb_pc,
    output isa_pkg::word_t      debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output isa_pkg::reg_idx_t   debug_wb_rf_wnum
);

    pipe_pkg::if_id_t   if_id;
    pipe_pkg::id_exe_t  id_exe;
    pipe_pkg::exe_mem_t exe_mem;
    pipe_pkg::mem_wb_t  mem_wb;
    pipe_pkg::fwd_t     mem_fwd;
    pipe_pkg::fwd_t     wb_fwd;    // rf write port and last bypass source
    logic               dep_stall;
    logic               branch_taken;
    isa_pkg::word_t     branch_target;

    fetch_stage u_fetch_stage (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .dep_stall     (dep_stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .inst_addr     (inst_addr),
        .inst_rdata    (inst_rdata),
        .if_id         (if_id)
    );

    decode_stage u_decode_stage (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .if_id        (if_id),
        .exe_mem      (exe_mem),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .branch_taken (branch_taken),
        .dep_stall    (dep_stall),
        .id_exe       (id_exe)
    );

    execute_stage u_execute_stage (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .id_exe        (id_exe),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exe_mem       (exe_mem)
    );

    memory_stage u_memory_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .exe_mem    (exe_mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .mem_fwd    (mem_fwd),
        .mem_wb     (mem_wb)
    );

    // writes to $0 never reach the rf or the trace
    assign wb_fwd.we    = mem_wb.valid && mem_wb.reg_write && (mem_wb.dst != '0);
    assign wb_fwd.dst   = mem_wb.dst;
    assign wb_fwd.value = mem_wb.result;

    // golden trace
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wdata = mem_wb.result;
    assign debug_wb_rf_wen   = wb_fwd.we ? 4'b1111 : 4'b0000;  // whole word or nothing
    assign debug_wb_rf_wnum  = mem_wb.dst;

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int NUM_TESTS  = 5;
    localparam int MAX_WORDS  = 16;
    localparam int MEM_WORDS  = 64;
    localparam int WAIT_LIMIT = 200;   // cycles per trace write

    logic                aclk;
    logic                arst_n;
    logic                ram_init;
    isa_pkg::word_t      inst_addr;
    isa_pkg::word_t      inst_rdata;
    pipe_pkg::dmem_req_t dmem_req;
    isa_pkg::word_t      dmem_rdata;
    isa_pkg::word_t      debug_wb_pc;
    isa_pkg::word_t      debug_wb_rf_wdata;
    logic [3:0]          debug_wb_rf_wen;
    isa_pkg::reg_idx_t   debug_wb_rf_wnum;

    isa_pkg::word_t rom       [MEM_WORDS];
    isa_pkg::word_t ram       [MEM_WORDS];
    isa_pkg::word_t model_ram [MEM_WORDS];

    // test table, one program per entry
    string          prog_name [NUM_TESTS];
    int             prog_len  [NUM_TESTS];
    isa_pkg::word_t prog_mem  [NUM_TESTS][MAX_WORDS];

    // expected trace from the reference model
    isa_pkg::word_t    exp_pc  [$];
    isa_pkg::reg_idx_t exp_num [$];
    isa_pkg::word_t    exp_val [$];

    integer seed;
    string  cur_name;
    int     err_count;
    int     test_errs;
    int     fail_tests;

    mips_core_top u_mips_core_top (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .dmem_req          (dmem_req),
        .dmem_rdata        (dmem_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    // both memories answer in the same cycle
    assign inst_rdata = rom[inst_addr[7:2]];
    assign dmem_rdata = ram[dmem_req.addr[7:2]];

    always @(posedge aclk) begin
        if (ram_init) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram[i[5:0]] <= fill_word(i);
            end
        end else if (dmem_req.enable && dmem_req.write) begin
            ram[dmem_req.addr[7:2]] <= dmem_req.wdata;   // store lands on the edge
        end
    end

    // whole byte address scrambled into the word
    function automatic isa_pkg::word_t fill_word(input int idx);
        isa_pkg::word_t addr;
        addr = idx * 4;
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [15:0] rand_imm();
        integer r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic isa_pkg::word_t rtype_word(input logic [5:0] fn,
        input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt);
        return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic isa_pkg::word_t itype_word(input logic [5:0] op,
        input isa_pkg::reg_idx_t rt, input isa_pkg::reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic push_instr(input int t, input isa_pkg::word_t w);
        prog_mem[t][prog_len[t][3:0]] = w;
        prog_len[t] = prog_len[t] + 1;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
        end
        prog_name[0] = "alu_independent";
        push_instr(0, itype_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, rand_imm()));
        push_instr(0, itype_word(isa_pkg::OP_ADDIU, 5'd2, 5'd0, rand_imm()));
        push_instr(0, itype_word(isa_pkg::OP_LUI, 5'd3, 5'd0, rand_imm()));
        push_instr(0, itype_word(isa_pkg::OP_ADDIU, 5'd4, 5'd0, rand_imm()));
        push_instr(0, itype_word(isa_pkg::OP_ADDIU, 5'd5, 5'd0, rand_imm()));
        push_instr(0, rtype_word(isa_pkg::FN_ADDU, 5'd6, 5'd1, 5'd2));
        push_instr(0, rtype_word(isa_pkg::FN_SUBU, 5'd7, 5'd1, 5'd2));
        push_instr(0, rtype_word(isa_pkg::FN_AND, 5'd8, 5'd3, 5'd4));
        push_instr(0, rtype_word(isa_pkg::FN_OR, 5'd9, 5'd1, 5'd5));
        push_instr(0, rtype_word(isa_pkg::FN_SLT, 5'd10, 5'd1, 5'd2));
        push_instr(0, rtype_word(isa_pkg::FN_SLT, 5'd11, 5'd2, 5'd1));
        // distances one, two and three
        prog_name[1] = "dep_distance";
        push_instr(1, itype_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, rand_imm()));
        push_instr(1, itype_word(isa_pkg::OP_ADDIU, 5'd2, 5'd1, rand_imm()));
        push_instr(1, rtype_word(isa_pkg::FN_ADDU, 5'd3, 5'd2, 5'd1));
        push_instr(1, rtype_word(isa_pkg::FN_SUBU, 5'd4, 5'd3, 5'd1));
        push_instr(1, rtype_word(isa_pkg::FN_OR, 5'd5, 5'd2, 5'd4));
        push_instr(1, rtype_word(isa_pkg::FN_SLT, 5'd6, 5'd5, 5'd2));
        push_instr(1, itype_word(isa_pkg::OP_ADDIU, 5'd7, 5'd6, rand_imm()));
        prog_name[2] = "store_load";
        push_instr(2, itype_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0010));  // base
        push_instr(2, itype_word(isa_pkg::OP_LUI, 5'd2, 5'd0, rand_imm()));
        push_instr(2, itype_word(isa_pkg::OP_ADDIU, 5'd2, 5'd2, rand_imm()));
        push_instr(2, itype_word(isa_pkg::OP_SW, 5'd2, 5'd1, 16'd4));
        push_instr(2, itype_word(isa_pkg::OP_LW, 5'd3, 5'd1, 16'd4));
        push_instr(2, rtype_word(isa_pkg::FN_ADDU, 5'd4, 5'd3, 5'd3));       // load use
        push_instr(2, itype_word(isa_pkg::OP_SW, 5'd4, 5'd1, 16'd8));
        push_instr(2, itype_word(isa_pkg::OP_LW, 5'd5, 5'd1, 16'd8));
        push_instr(2, itype_word(isa_pkg::OP_LW, 5'd6, 5'd1, 16'd12));      // untouched word
        prog_name[3] = "beq_branch";
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, rand_imm()));
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd2, 5'd1, 16'd0));
        push_instr(3, itype_word(isa_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));       // taken
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd1));
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd4, 5'd0, 16'd2));
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd5, 5'd1, 16'd1));
        push_instr(3, itype_word(isa_pkg::OP_BEQ, 5'd5, 5'd1, 16'd1));       // not taken
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd6, 5'd0, 16'd4));
        push_instr(3, itype_word(isa_pkg::OP_ADDIU, 5'd7, 5'd6, 16'd5));
        prog_name[4] = "zero_dest";
        push_instr(4, itype_word(isa_pkg::OP_ADDIU, 5'd0, 5'd0, rand_imm()));
        push_instr(4, rtype_word(isa_pkg::FN_ADDU, 5'd1, 5'd0, 5'd0));
        push_instr(4, itype_word(isa_pkg::OP_ADDIU, 5'd2, 5'd0, rand_imm()));
        push_instr(4, rtype_word(isa_pkg::FN_OR, 5'd0, 5'd2, 5'd2));
        push_instr(4, rtype_word(isa_pkg::FN_ADDU, 5'd3, 5'd0, 5'd2));
        push_instr(4, itype_word(isa_pkg::OP_LW, 5'd0, 5'd0, 16'd0));
        push_instr(4, rtype_word(isa_pkg::FN_OR, 5'd4, 5'd0, 5'd3));
    endtask

    // in-order ISA interpreter, no delay slot
    task automatic run_model(input int t);
        isa_pkg::word_t    gpr [isa_pkg::NUM_REGS];
        isa_pkg::word_t    pc, cur_pc, instr, a, b, simm, ea, wval;
        isa_pkg::reg_idx_t wnum;
        logic              wr;
        int                steps;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            gpr[i[4:0]] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_ram[i[5:0]] = fill_word(i);
        end
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        pc    = isa_pkg::RESET_PC;
        steps = 0;
        while ((pc >> 2) < isa_pkg::word_t'(prog_len[t]) && steps < 64) begin
            cur_pc = pc;
            instr  = prog_mem[t][pc[5:2]];
            a      = gpr[instr[25:21]];
            b      = gpr[instr[20:16]];
            simm   = {{16{instr[15]}}, instr[15:0]};
            ea     = a + simm;
            wnum   = instr[20:16];
            wval   = '0;
            wr     = 1'b1;
            pc     = pc + 32'd4;
            case (instr[31:26])
                isa_pkg::OP_SPECIAL: begin
                    wnum = instr[15:11];
                    case (instr[5:0])
                        isa_pkg::FN_ADDU: wval = a + b;
                        isa_pkg::FN_SUBU: wval = a - b;
                        isa_pkg::FN_AND:  wval = a & b;
                        isa_pkg::FN_OR:   wval = a | b;
                        isa_pkg::FN_SLT:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                isa_pkg::OP_ADDIU: wval = ea;
                isa_pkg::OP_LUI:   wval = {instr[15:0], 16'h0000};
                isa_pkg::OP_LW:    wval = model_ram[ea[7:2]];
                isa_pkg::OP_SW: begin
                    model_ram[ea[7:2]] = b;
                    wr = 1'b0;
                end
                isa_pkg::OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        pc = pc + {simm[29:0], 2'b00};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && wnum != '0) begin  // $0 stays zero, no trace
                gpr[wnum] = wval;
                exp_pc.push_back(cur_pc);
                exp_num.push_back(wnum);
                exp_val.push_back(wval);
            end
            steps++;
        end
    endtask

    task automatic check_value(input string what, input isa_pkg::word_t expected,
        input isa_pkg::word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH test %s %s: expected 0x%08h actual 0x%08h",
                     cur_name, what, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic wait_trace_write(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge aclk);
            cycles++;
            seen = (debug_wb_rf_wen != 4'b0000);
        end
    endtask

    task automatic run_test(input int t);
        bit seen;
        cur_name  = prog_name[t];
        test_errs = 0;
        @(posedge aclk);
        arst_n   <= 1'b0;
        ram_init <= 1'b1;
        @(negedge aclk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i[5:0]] = (i < prog_len[t]) ? prog_mem[t][i[3:0]] : '0;  // nops past the end
        end
        run_model(t);
        @(posedge aclk);
        ram_init <= 1'b0;
        repeat (7) @(posedge aclk);
        arst_n <= 1'b1;
        @(negedge aclk);
        check_value("wen after reset", 32'd0, {28'd0, debug_wb_rf_wen});
        check_value("first inst_addr", isa_pkg::RESET_PC, inst_addr);
        for (int k = 0; k < exp_pc.size(); k++) begin
            wait_trace_write(seen);
            if (!seen) begin
                $display("ERROR test %s: no register write for pc 0x%08h within %0d cycles",
                         cur_name, exp_pc[k], WAIT_LIMIT);
                err_count++;
                test_errs++;
                break;
            end
            check_value("wen", 32'hf, {28'd0, debug_wb_rf_wen});
            check_value("wb pc", exp_pc[k], debug_wb_pc);
            check_value("wb reg", {27'd0, exp_num[k]}, {27'd0, debug_wb_rf_wnum});
            check_value("wb data", exp_val[k], debug_wb_rf_wdata);
        end
        // trailing nops must stay silent
        repeat (10) begin
            @(negedge aclk);
            if (debug_wb_rf_wen != 4'b0000) begin
                $display("ERROR test %s: unexpected register write to $%0d at pc 0x%08h",
                         cur_name, debug_wb_rf_wnum, debug_wb_pc);
                err_count++;
                test_errs++;
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("ram word %0d", i), model_ram[i[5:0]], ram[i[5:0]]);
        end
        if (test_errs != 0) begin
            fail_tests++;
        end
        $display("test %0d %s: %0d writes, %0d errors, %s", t, cur_name, exp_pc.size(),
                 test_errs, (test_errs == 0) ? "pass" : "fail");
    endtask

    initial begin
        arst_n     = 1'b0;
        ram_init   = 1'b0;
        seed       = 32'he27c;
        err_count  = 0;
        fail_tests = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i[5:0]] = '0;
        end
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, fail_tests, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core_top.sv
sim/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module tb_top -f sim.f -Mdir obj_dir -o tb_top_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
